// ==== src/mem_access_params.svh ====
`ifndef MEM_ACCESS_PARAMS_SVH
`define MEM_ACCESS_PARAMS_SVH

// data path and page geometry
`define MA_WORD_W       32
`define MA_PFN_W        20
`define MA_PAGE_OFS_W   12

`define MA_CATTR_CACHED 3'd3    // cacheable, noncoherent

// unmapped segments, vaddr[31:29]
`define MA_SEG_KSEG0    3'b100
`define MA_SEG_KSEG1    3'b101

// stores first, so op <= SC means a store
`define MA_OP_SB        4'd0
`define MA_OP_SH        4'd1
`define MA_OP_SW        4'd2
`define MA_OP_SWL       4'd3
`define MA_OP_SWR       4'd4
`define MA_OP_SC        4'd5
`define MA_OP_LB        4'd6
`define MA_OP_LBU       4'd7
`define MA_OP_LH        4'd8
`define MA_OP_LHU       4'd9
`define MA_OP_LW        4'd10
`define MA_OP_LL        4'd11

// cause register exception codes
`define MA_EXC_MOD      5'd1
`define MA_EXC_TLBL     5'd2
`define MA_EXC_TLBS     5'd3
`define MA_EXC_ADEL     5'd4
`define MA_EXC_ADES     5'd5

`define MA_FSM_STATES   5

`endif

// ==== src/mem_access_pkg.sv ====
`include "mem_access_params.svh"

package mem_access_pkg;

    typedef logic [`MA_WORD_W-1:0]                  word_t;
    typedef logic [`MA_WORD_W-1:0]                  vaddr_t;
    typedef logic [`MA_WORD_W-1:0]                  paddr_t;
    typedef logic [`MA_PFN_W-1:0]                   pfn_t;
    typedef logic [`MA_WORD_W-`MA_PAGE_OFS_W-1:0]   vpn_t;

    typedef logic [2:0]                             cattr_t;     // tlb C field
    typedef logic [`MA_WORD_W/8-1:0]                strb_t;      // one bit per byte lane
    typedef logic [3:0]                             mem_op_t;
    typedef logic [4:0]                             exc_code_t;

    // 0 byte, 1 half, 2 word
    typedef logic [1:0]                             bus_size_t;

    // one request in flight at a time
    typedef enum logic [$clog2(`MA_FSM_STATES)-1:0] {
        IDLE,
        LOOKUP,
        BUS_REQ,
        BUS_WAIT,
        RESP
    } fsm_state_t;

endpackage

// ==== src/xlate_if.sv ====
`timescale 1ns/1ps

interface xlate_if
    import mem_access_pkg::*;
();
    paddr_t paddr;          // physical address of the access
    logic   cached;
    logic   mapped;         // address goes through the tlb
    logic   tlb_refill;     // no matching entry
    logic   tlb_invalid;    // entry found, V clear
    logic   tlb_mod;        // store to a clean page

    modport producer (
        output paddr,
        output cached,
        output mapped,
        output tlb_refill,
        output tlb_invalid,
        output tlb_mod
    );

    modport consumer (
        input paddr,
        input cached,
        input mapped,
        input tlb_refill,
        input tlb_invalid,
        input tlb_mod
    );

endinterface

// ==== src/addr_translate.sv ====
`timescale 1ns/1ps
`include "mem_access_params.svh"

module addr_translate
    import mem_access_pkg::*;
(
    input  vaddr_t    vaddr,
    input  logic      tlb_found,
    input  logic      tlb_valid,
    input  logic      tlb_dirty,
    input  pfn_t      tlb_pfn,
    input  cattr_t    tlb_cattr,
    input  cattr_t    k0_cattr,
    input  logic      is_store,
    xlate_if.producer xl
);
    logic [2:0] seg;
    logic       in_kseg0;
    logic       in_kseg1;
    logic       mapped;

    assign seg      = vaddr[31:29];
    assign in_kseg0 = (seg == `MA_SEG_KSEG0);
    assign in_kseg1 = (seg == `MA_SEG_KSEG1);

    // same as !vaddr[31] || vaddr[31:30] == 2'b11
    assign mapped    = !(in_kseg0 || in_kseg1);
    assign xl.mapped = mapped;

    // kseg0/kseg1 just drop the segment bits
    assign xl.paddr = mapped ? {tlb_pfn, vaddr[`MA_PAGE_OFS_W-1:0]}
                             : {3'b000, vaddr[28:0]};

    always_comb begin
        if (in_kseg1)
            xl.cached = 1'b0;   // kseg1 is always uncached
        else if (in_kseg0)
            xl.cached = (k0_cattr == `MA_CATTR_CACHED);
        else
            xl.cached = (tlb_cattr == `MA_CATTR_CACHED);
    end

    // fault kinds, only meaningful for mapped space
    assign xl.tlb_refill  = mapped && !tlb_found;
    assign xl.tlb_invalid = mapped && tlb_found && !tlb_valid;
    assign xl.tlb_mod     = mapped && tlb_found && tlb_valid && is_store && !tlb_dirty;

endmodule

// ==== src/exc_detect.sv ====
`timescale 1ns/1ps
`include "mem_access_params.svh"

module exc_detect
    import mem_access_pkg::*;
(
    input  mem_op_t   op,
    input  vaddr_t    vaddr,
    xlate_if.consumer xl,
    output logic      exc,
    output exc_code_t exc_code,
    output logic      tlb_refill,
    output vaddr_t    badvaddr
);
    logic is_store;
    logic half_mis;     // odd address
    logic word_mis;
    logic adel;
    logic ades;
    logic tlb_miss;

    assign is_store = (op <= `MA_OP_SC);
    assign half_mis = vaddr[0];
    assign word_mis = (vaddr[1:0] != 2'b00);

    assign adel = ((op == `MA_OP_LH || op == `MA_OP_LHU) && half_mis) ||
                  ((op == `MA_OP_LW || op == `MA_OP_LL) && word_mis);

    // swl/swr accept any byte address
    assign ades = (op == `MA_OP_SH && half_mis) ||
                  ((op == `MA_OP_SW || op == `MA_OP_SC) && word_mis);

    assign tlb_miss = xl.mapped && (xl.tlb_refill || xl.tlb_invalid);

    // address errors win over tlb faults
    always_comb begin
        exc      = 1'b1;
        exc_code = '0;
        if (adel)
            exc_code = `MA_EXC_ADEL;
        else if (ades)
            exc_code = `MA_EXC_ADES;
        else if (tlb_miss)
            exc_code = is_store ? `MA_EXC_TLBS : `MA_EXC_TLBL;
        else if (xl.tlb_mod)
            exc_code = `MA_EXC_MOD;
        else
            exc = 1'b0;
    end

    // refill takes the dedicated vector, unless an address error came first
    assign tlb_refill = xl.tlb_refill && !adel && !ades;
    assign badvaddr   = exc ? vaddr : '0;

endmodule

// ==== src/store_align.sv ====
`timescale 1ns/1ps
`include "mem_access_params.svh"

module store_align
    import mem_access_pkg::*;
(
    input  mem_op_t    op,
    input  logic [1:0] paddr_low,
    input  word_t      rt,
    output strb_t      wstrb,
    output word_t      wdata,
    output bus_size_t  size
);
    always_comb begin
        case (op)
            `MA_OP_SB:             wstrb = 4'b0001 << paddr_low;
            `MA_OP_SH:             wstrb = paddr_low[1] ? 4'b1100 : 4'b0011;
            `MA_OP_SWL:            wstrb = 4'b1111 >> (~paddr_low);   // fills toward byte 0
            `MA_OP_SWR:            wstrb = 4'b1111 << paddr_low;      // fills toward byte 3
            `MA_OP_SW, `MA_OP_SC:  wstrb = 4'b1111;
            default:               wstrb = 4'b0000;                   // loads
        endcase
    end

    // lane placement, replicated where the strobe picks the lane
    always_comb begin
        case (op)
            `MA_OP_SB: wdata = {4{rt[7:0]}};
            `MA_OP_SH: wdata = {2{rt[15:0]}};
            `MA_OP_SWL: begin
                case (paddr_low)
                    2'b00:   wdata = {4{rt[31:24]}};
                    2'b01:   wdata = {2{rt[31:16]}};
                    2'b10:   wdata = {8'd0, rt[31:8]};
                    default: wdata = rt;
                endcase
            end
            `MA_OP_SWR: begin
                case (paddr_low)
                    2'b00:   wdata = rt;
                    2'b01:   wdata = {rt[23:0], 8'd0};
                    2'b10:   wdata = {2{rt[15:0]}};
                    default: wdata = {4{rt[7:0]}};
                endcase
            end
            default: wdata = rt;
        endcase
    end

    always_comb begin
        case (op)
            `MA_OP_SB, `MA_OP_LB, `MA_OP_LBU: size = 2'd0;
            `MA_OP_SH, `MA_OP_LH, `MA_OP_LHU: size = 2'd1;
            default:                          size = 2'd2;   // swl/swr are word sized too
        endcase
    end

endmodule

// ==== src/load_align.sv ====
`timescale 1ns/1ps
`include "mem_access_params.svh"

module load_align
    import mem_access_pkg::*;
(
    input  mem_op_t    op,
    input  logic [1:0] addr_low,
    input  word_t      rdata_raw,
    output word_t      rdata
);
    logic [7:0]  byte_sel;
    logic [15:0] half_sel;

    // bus returns the whole word, pick the addressed lane
    assign byte_sel = rdata_raw[{addr_low, 3'b000} +: 8];
    assign half_sel = addr_low[1] ? rdata_raw[31:16] : rdata_raw[15:0];

    always_comb begin
        case (op)
            `MA_OP_LB:  rdata = {{24{byte_sel[7]}}, byte_sel};
            `MA_OP_LBU: rdata = {24'd0, byte_sel};
            `MA_OP_LH:  rdata = {{16{half_sel[15]}}, half_sel};
            `MA_OP_LHU: rdata = {16'd0, half_sel};
            default:    rdata = rdata_raw;     // lw, ll
        endcase
    end

endmodule

// ==== src/ll_link.sv ====
`timescale 1ns/1ps

module ll_link
    import mem_access_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  logic   link_set,
    input  logic   link_clear,
    input  vaddr_t vaddr,
    output logic   sc_ok
);
    logic   link_bit;
    vaddr_t link_addr;   // virtual address of the last ll

    always_ff @(posedge clk) begin
        if (!rst_n || link_clear) begin
            link_bit  <= 1'b0;
            link_addr <= '0;
        end else if (link_set) begin
            link_bit  <= 1'b1;
            link_addr <= vaddr;
        end
    end

    // sc leaves the link alone
    assign sc_ok = link_bit && (link_addr == vaddr);

endmodule

// ==== src/access_fsm.sv ====
`timescale 1ns/1ps
`include "mem_access_params.svh"

module access_fsm
    import mem_access_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       req_valid,
    output logic       req_ready,
    input  mem_op_t    req_op,
    input  vaddr_t     req_vaddr,
    input  word_t      req_rt,
    xlate_if.consumer  xl,
    input  logic       exc,
    input  logic       sc_ok,
    output logic       link_set,
    output logic       link_clear,
    output mem_op_t    cur_op,
    output vaddr_t     cur_vaddr,
    output word_t      cur_rt,
    output logic       bus_req,
    input  logic       bus_addr_ok,
    input  logic       bus_data_ok,
    input  word_t      bus_rdata,
    output word_t      rdata_raw,
    output logic       resp_valid,
    input  logic       resp_ready,
    output logic       resp_exc,
    output logic [1:0] resp_data_sel
);
    fsm_state_t state;
    fsm_state_t state_nxt;
    logic       is_load;
    logic       is_sc;
    logic       fault;
    logic       skip_bus;
    logic       sc_pass;    // sc outcome seen in LOOKUP

    assign is_load = (cur_op >= `MA_OP_LB);
    assign is_sc   = (cur_op == `MA_OP_SC);

    // tlb fault kinds also keep the access off the bus
    assign fault    = exc || xl.tlb_refill || xl.tlb_invalid || xl.tlb_mod;
    assign skip_bus = fault || (is_sc && !sc_ok);

    assign req_ready  = (state == IDLE);
    assign bus_req    = (state == BUS_REQ);
    assign resp_valid = (state == RESP);
    assign link_set   = (state == LOOKUP) && !fault && (cur_op == `MA_OP_LL);
    assign link_clear = (state == LOOKUP) && fault;

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (req_valid)
                    state_nxt = LOOKUP;
            end
            LOOKUP: begin
                state_nxt = skip_bus ? RESP : BUS_REQ;   // always one cycle
            end
            BUS_REQ: begin
                if (bus_addr_ok)
                    state_nxt = BUS_WAIT;
            end
            BUS_WAIT: begin
                if (bus_data_ok)
                    state_nxt = RESP;
            end
            RESP: begin
                if (resp_ready)
                    state_nxt = IDLE;
            end
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n)
            state <= IDLE;
        else
            state <= state_nxt;
    end

    // request held until the response leaves
    always_ff @(posedge clk) begin
        if (req_valid && req_ready) begin
            cur_op    <= req_op;
            cur_vaddr <= req_vaddr;
            cur_rt    <= req_rt;
        end
    end

    always_ff @(posedge clk) begin
        if (state == BUS_WAIT && bus_data_ok)
            rdata_raw <= bus_rdata;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            resp_exc <= 1'b0;
            sc_pass  <= 1'b0;
        end else if (state == LOOKUP) begin
            resp_exc <= fault;
            sc_pass  <= is_sc && sc_ok && !fault;
        end
    end

    // [1] selects load data, [0] is the sc result bit
    assign resp_data_sel = {is_load && !resp_exc, sc_pass};

endmodule

// ==== src/mem_access_top.sv ====
`timescale 1ns/1ps
`include "mem_access_params.svh"

module mem_access_top
    import mem_access_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    // request
    input  logic      req_valid,
    output logic      req_ready,
    input  mem_op_t   req_op,
    input  vaddr_t    req_vaddr,
    input  word_t     req_rt,
    // tlb lookup, answered in the same cycle
    output vpn_t      tlb_vpn,
    input  logic      tlb_found,
    input  logic      tlb_valid,
    input  logic      tlb_dirty,
    input  pfn_t      tlb_pfn,
    input  cattr_t    tlb_cattr,
    input  cattr_t    k0_cattr,
    // memory bus
    output logic      bus_req,
    output logic      bus_wr,
    output paddr_t    bus_addr,
    output bus_size_t bus_size,
    output strb_t     bus_wstrb,
    output word_t     bus_wdata,
    output logic      bus_cached,
    input  logic      bus_addr_ok,
    input  logic      bus_data_ok,
    input  word_t     bus_rdata,
    // response
    output logic      resp_valid,
    input  logic      resp_ready,
    output logic      resp_exc,
    output exc_code_t resp_exc_code,
    output logic      resp_tlb_refill,
    output vaddr_t    resp_badvaddr,
    output word_t     resp_rdata
);
    xlate_if xl_i ();

    mem_op_t    cur_op;
    vaddr_t     cur_vaddr;
    word_t      cur_rt;
    word_t      rdata_raw;
    word_t      load_data;
    logic       is_store;
    logic       exc;
    logic       sc_ok;
    logic       link_set;
    logic       link_clear;
    logic [1:0] resp_data_sel;

    assign tlb_vpn    = cur_vaddr[`MA_WORD_W-1:`MA_PAGE_OFS_W];
    assign is_store   = (cur_op <= `MA_OP_SC);
    assign bus_wr     = is_store;
    assign bus_addr   = xl_i.paddr;
    assign bus_cached = xl_i.cached;

    // sc reports 1/0, stores and faults return zero
    assign resp_rdata = resp_data_sel[1] ? load_data
                                         : {{(`MA_WORD_W-1){1'b0}}, resp_data_sel[0]};

    addr_translate u_xlate (
        .vaddr     (cur_vaddr),
        .tlb_found (tlb_found),
        .tlb_valid (tlb_valid),
        .tlb_dirty (tlb_dirty),
        .tlb_pfn   (tlb_pfn),
        .tlb_cattr (tlb_cattr),
        .k0_cattr  (k0_cattr),
        .is_store  (is_store),
        .xl        (xl_i.producer)
    );

    exc_detect u_exc (
        .op         (cur_op),
        .vaddr      (cur_vaddr),
        .xl         (xl_i.consumer),
        .exc        (exc),
        .exc_code   (resp_exc_code),
        .tlb_refill (resp_tlb_refill),
        .badvaddr   (resp_badvaddr)
    );

    store_align u_store (
        .op        (cur_op),
        .paddr_low (xl_i.paddr[1:0]),
        .rt        (cur_rt),
        .wstrb     (bus_wstrb),
        .wdata     (bus_wdata),
        .size      (bus_size)
    );

    load_align u_load (
        .op        (cur_op),
        .addr_low  (cur_vaddr[1:0]),
        .rdata_raw (rdata_raw),
        .rdata     (load_data)
    );

    ll_link u_link (
        .clk        (clk),
        .rst_n      (rst_n),
        .link_set   (link_set),
        .link_clear (link_clear),
        .vaddr      (cur_vaddr),
        .sc_ok      (sc_ok)
    );

    access_fsm u_fsm (
        .clk           (clk),
        .rst_n         (rst_n),
        .req_valid     (req_valid),
        .req_ready     (req_ready),
        .req_op        (req_op),
        .req_vaddr     (req_vaddr),
        .req_rt        (req_rt),
        .xl            (xl_i.consumer),
        .exc           (exc),
        .sc_ok         (sc_ok),
        .link_set      (link_set),
        .link_clear    (link_clear),
        .cur_op        (cur_op),
        .cur_vaddr     (cur_vaddr),
        .cur_rt        (cur_rt),
        .bus_req       (bus_req),
        .bus_addr_ok   (bus_addr_ok),
        .bus_data_ok   (bus_data_ok),
        .bus_rdata     (bus_rdata),
        .rdata_raw     (rdata_raw),
        .resp_valid    (resp_valid),
        .resp_ready    (resp_ready),
        .resp_exc      (resp_exc),
        .resp_data_sel (resp_data_sel)
    );

endmodule

// ==== tests/tb_mem_model.svh ====
`ifndef TB_MEM_MODEL_SVH
`define TB_MEM_MODEL_SVH

function automatic logic op_is_store(input mem_op_t op);
    case (op)
        `MA_OP_SB, `MA_OP_SH, `MA_OP_SW, `MA_OP_SWL, `MA_OP_SWR, `MA_OP_SC: return 1'b1;
        default: return 1'b0;
    endcase
endfunction

// mapped unless bits 31:30 are 2'b10
function automatic logic va_mapped(input vaddr_t va);
    return !va[31] || (va[31:30] == 2'b11);
endfunction

task automatic model_translate(input vaddr_t va, input cattr_t k0,
                               output paddr_t pa, output logic cached);
    int e;
    e = va[14:12];
    if (va_mapped(va)) begin
        pa     = {tlb_pfn_tab[e], va[11:0]};
        cached = (tlb_cattr_tab[e] == `MA_CATTR_CACHED);
    end else begin
        pa     = va & 32'h1fff_ffff;
        cached = !va[29] && (k0 == `MA_CATTR_CACHED);   // kseg1 never cached
    end
endtask

task automatic model_exc(input mem_op_t op, input vaddr_t va, output logic exc,
                         output exc_code_t code, output logic refill);
    int   e;
    logic st;
    logic adel;
    logic ades;
    logic miss;
    logic inval;
    logic clean;
    e     = va[14:12];
    st    = op_is_store(op);
    adel  = ((op == `MA_OP_LH || op == `MA_OP_LHU) && va[0]) ||
            ((op == `MA_OP_LW || op == `MA_OP_LL) && va[1:0] != 2'b00);
    ades  = (op == `MA_OP_SH && va[0]) ||
            ((op == `MA_OP_SW || op == `MA_OP_SC) && va[1:0] != 2'b00);
    miss  = va_mapped(va) && !tlb_found_tab[e];
    inval = va_mapped(va) && tlb_found_tab[e] && !tlb_valid_tab[e];
    clean = va_mapped(va) && tlb_found_tab[e] && tlb_valid_tab[e] && st && !tlb_dirty_tab[e];
    exc   = 1'b1;
    code  = '0;
    if (adel)
        code = `MA_EXC_ADEL;
    else if (ades)
        code = `MA_EXC_ADES;
    else if (miss || inval)
        code = st ? `MA_EXC_TLBS : `MA_EXC_TLBL;
    else if (clean)
        code = `MA_EXC_MOD;
    else
        exc = 1'b0;
    refill = miss && !adel && !ades;
endtask

// which rt byte lands in memory byte i, -1 if untouched (little endian)
function automatic int lane_src(input mem_op_t op, input logic [1:0] a, input int i);
    int ai;
    ai = a;
    case (op)
        `MA_OP_SB:            return (i == ai) ? 0 : -1;
        `MA_OP_SH:            return (i / 2 == ai / 2) ? i % 2 : -1;
        `MA_OP_SW, `MA_OP_SC: return i;
        `MA_OP_SWL:           return (i <= ai) ? 3 - ai + i : -1;   // upper bytes of rt
        `MA_OP_SWR:           return (i >= ai) ? i - ai : -1;
        default:              return -1;
    endcase
endfunction

function automatic bus_size_t access_size(input mem_op_t op);
    case (op)
        `MA_OP_SB, `MA_OP_LB, `MA_OP_LBU: return 2'd0;
        `MA_OP_SH, `MA_OP_LH, `MA_OP_LHU: return 2'd1;
        default:                          return 2'd2;
    endcase
endfunction

function automatic word_t load_extract(input mem_op_t op, input logic [1:0] a, input word_t w);
    logic [7:0]  b;
    logic [15:0] h;
    b = w[a*8 +: 8];
    h = a[1] ? w[31:16] : w[15:0];
    case (op)
        `MA_OP_LB:  return {{24{b[7]}}, b};
        `MA_OP_LBU: return {24'd0, b};
        `MA_OP_LH:  return {{16{h[15]}}, h};
        `MA_OP_LHU: return {16'd0, h};
        default:    return w;
    endcase
endfunction

function automatic logic [7:0] fill_byte(input int i);
    return i[7:0] ^ {i[3:0], i[7:4]} ^ 8'ha5;
endfunction

function automatic word_t ref_word(input paddr_t pa);
    word_t w;
    int    i;
    for (i = 0; i < 4; i++)
        w[i*8 +: 8] = ref_mem[{pa[7:2], i[1:0]}];
    return w;
endfunction

task automatic ref_store(input paddr_t pa, input strb_t strb, input word_t lanes);
    int i;
    for (i = 0; i < 4; i++)
        if (strb[i])
            ref_mem[{pa[7:2], i[1:0]}] = lanes[i*8 +: 8];
endtask

`endif

// ==== tests/tb_mem_access.sv ====
`timescale 1ns/1ps
`include "mem_access_params.svh"

module tb_mem_access
    import mem_access_pkg::*;
();
    localparam int CLK_PERIOD  = 20;
    localparam int N_REQ       = 500;
    localparam int MAX_REQ_CYC = 60;   // generous bound per request
    localparam logic [15:0] SEED = 16'd39619;

    logic      clk = 1'b0;
    logic      rst_n;
    logic      req_valid;
    logic      req_ready;
    mem_op_t   req_op;
    vaddr_t    req_vaddr;
    word_t     req_rt;
    vpn_t      tlb_vpn;
    logic      tlb_found;
    logic      tlb_valid;
    logic      tlb_dirty;
    pfn_t      tlb_pfn;
    cattr_t    tlb_cattr;
    cattr_t    k0_cattr;
    logic      bus_req;
    logic      bus_wr;
    paddr_t    bus_addr;
    bus_size_t bus_size;
    strb_t     bus_wstrb;
    word_t     bus_wdata;
    logic      bus_cached;
    logic      bus_addr_ok;
    logic      bus_data_ok;
    word_t     bus_rdata;
    logic      resp_valid;
    logic      resp_ready;
    logic      resp_exc;
    exc_code_t resp_exc_code;
    logic      resp_tlb_refill;
    vaddr_t    resp_badvaddr;
    word_t     resp_rdata;

    // tlb contents indexed by the low vpn bits
    logic       tlb_found_tab [8];
    logic       tlb_valid_tab [8];
    logic       tlb_dirty_tab [8];
    pfn_t       tlb_pfn_tab   [8];
    cattr_t     tlb_cattr_tab [8];
    logic [2:0] tlb_idx;

    logic [7:0]  bus_mem [256];   // written by the DUT
    logic [7:0]  ref_mem [256];   // written by the model
    logic        link_bit;
    vaddr_t      link_addr;
    logic [15:0] stim_st;
    logic [15:0] bus_st;
    logic [15:0] rdy_st;
    int          checks;
    int          val_errs;
    int          proto_errs;

    `include "tb_mem_model.svh"

    mem_access_top dut0 (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    // tlb answers in the same cycle
    // vpn stays X until the first request
    assign tlb_idx   = $isunknown(tlb_vpn) ? 3'd0 : tlb_vpn[2:0];
    assign tlb_found = tlb_found_tab[tlb_idx];
    assign tlb_valid = tlb_valid_tab[tlb_idx];
    assign tlb_dirty = tlb_dirty_tab[tlb_idx];
    assign tlb_pfn   = tlb_pfn_tab[tlb_idx];
    assign tlb_cattr = tlb_cattr_tab[tlb_idx];

    // fibonacci lfsr for x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [31:0] lfsr_take(inout logic [15:0] st, input int n);
        logic [31:0] v;
        logic        fb;
        int          i;
        v = '0;
        for (i = 0; i < n; i++) begin
            fb = st[15] ^ st[13] ^ st[12] ^ st[10];
            st = {st[14:0], fb};
            v  = {v[30:0], fb};
        end
        return v;
    endfunction

    task automatic check_val(input string name, input logic [31:0] act, input logic [31:0] exp);
        checks++;
        if (act !== exp) begin
            val_errs++;
            $display("Error: %s is %h, expected %h at %0t", name, act, exp, $time);
        end
    endtask

    task automatic flag_problem(input string msg);
        proto_errs++;
        $display("%s at %0t", msg, $time);
    endtask

    task automatic run_request(input mem_op_t op, input vaddr_t va, input word_t rt,
                               input cattr_t k0, input int gap);
        paddr_t      pa;
        logic        cached;
        logic        exc;
        logic        refill;
        logic        no_bus;
        logic        held;
        logic        done;
        exc_code_t   code;
        word_t       exp_data;
        word_t       exp_lanes;
        word_t       mask;
        strb_t       exp_strb;
        logic [70:0] snap;
        int          cyc;
        int          accepts;
        int          i;
        int          src;

        repeat (gap) @(posedge clk);
        @(posedge clk);
        req_valid <= 1'b1;
        req_op    <= op;
        req_vaddr <= va;
        req_rt    <= rt;
        k0_cattr  <= k0;
        @(negedge clk);
        while (!req_ready) @(negedge clk);
        @(posedge clk);                       // transfer edge
        req_valid <= 1'b0;

        model_translate(va, k0, pa, cached);
        model_exc(op, va, exc, code, refill);
        no_bus    = exc || (op == `MA_OP_SC && !(link_bit && link_addr == va));
        exp_strb  = '0;
        exp_lanes = '0;
        mask      = '0;
        for (i = 0; i < 4; i++) begin
            src = lane_src(op, va[1:0], i);
            if (src >= 0) begin
                exp_strb[i]         = 1'b1;
                exp_lanes[i*8 +: 8] = rt[src*8 +: 8];
                mask[i*8 +: 8]      = 8'hff;
            end
        end
        if (exc)
            exp_data = '0;
        else if (op == `MA_OP_SC)
            exp_data = {31'd0, !no_bus};
        else if (op_is_store(op))
            exp_data = '0;
        else
            exp_data = load_extract(op, va[1:0], ref_word(pa));
        if (exc) begin
            link_bit = 1'b0;
        end else if (op == `MA_OP_LL) begin
            link_bit  = 1'b1;
            link_addr = va;
        end
        if (!no_bus)
            ref_store(pa, exp_strb, exp_lanes);

        cyc     = 0;
        accepts = 0;
        held    = 1'b0;
        done    = 1'b0;
        while (!done) begin
            @(negedge clk);
            cyc++;
            check_val("req_ready", req_ready, 1'b0);
            check_val("tlb_vpn", tlb_vpn, va[31:12]);
            if (bus_req) begin
                if (no_bus)
                    flag_problem("bus request seen for an access that must stay off the bus");
                check_val("bus_addr", bus_addr, pa);
                check_val("bus_wr", bus_wr, op_is_store(op));
                check_val("bus_size", bus_size, access_size(op));
                check_val("bus_wstrb", bus_wstrb, exp_strb);
                check_val("bus_wdata", bus_wdata & mask, exp_lanes);
                check_val("bus_cached", bus_cached, cached);
                if (bus_addr_ok)
                    accepts++;
            end
            if (resp_valid) begin
                if (!held) begin
                    if (no_bus)
                        check_val("resp latency", cyc, 2);
                    check_val("resp_exc", resp_exc, exc);
                    check_val("resp_exc_code", resp_exc_code, code);
                    check_val("resp_tlb_refill", resp_tlb_refill, refill);
                    check_val("resp_badvaddr", resp_badvaddr, exc ? va : 32'd0);
                    check_val("resp_rdata", resp_rdata, exp_data);
                    snap = {resp_exc, resp_exc_code, resp_tlb_refill, resp_badvaddr, resp_rdata};
                    held = 1'b1;
                end else if ({resp_exc, resp_exc_code, resp_tlb_refill, resp_badvaddr,
                              resp_rdata} !== snap) begin
                    flag_problem("response fields changed while resp_valid was held");
                end
                done = resp_ready;
            end
        end
        check_val("bus accepts", accepts, no_bus ? 0 : 1);
    endtask

    // one data_ok pulse per accepted request
    initial begin : bus_responder
        paddr_t a;
        word_t  w;
        int     d;
        int     i;
        forever begin
            @(posedge clk);
            bus_data_ok <= 1'b0;
            bus_addr_ok <= 1'(lfsr_take(bus_st, 1));
            @(negedge clk);
            if (bus_req && bus_addr_ok) begin
                a = bus_addr;
                for (i = 0; i < 4; i++) begin
                    if (bus_wr && bus_wstrb[i])
                        bus_mem[{a[7:2], i[1:0]}] = bus_wdata[i*8 +: 8];
                    w[i*8 +: 8] = bus_mem[{a[7:2], i[1:0]}];
                end
                d = lfsr_take(bus_st, 2);
                @(posedge clk);
                bus_addr_ok <= 1'b0;
                repeat (d) @(posedge clk);
                bus_data_ok <= 1'b1;
                bus_rdata   <= w;
            end
        end
    end

    initial begin : resp_drainer
        forever begin
            @(posedge clk);
            resp_ready <= (2'(lfsr_take(rdy_st, 2)) != 2'd0);   // ready 3 of 4 cycles
        end
    end

    initial begin : watchdog
        #(CLK_PERIOD * (N_REQ * MAX_REQ_CYC + 10));
        $display("timeout: the DUT stopped completing requests");
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin : stimulus
        mem_op_t    op;
        vaddr_t     va;
        vaddr_t     last_va;
        vaddr_t     ll_va;
        word_t      rt;
        cattr_t     k0;
        logic [2:0] seg;
        logic [2:0] page;
        logic [1:0] wsel;
        logic [1:0] lo;
        int         gap;
        int         n;
        int         i;

        rst_n       = 1'b0;
        req_valid   = 1'b0;
        req_op      = '0;
        req_vaddr   = '0;
        req_rt      = '0;
        k0_cattr    = '0;
        bus_addr_ok = 1'b0;
        bus_data_ok = 1'b0;
        bus_rdata   = '0;
        resp_ready  = 1'b0;
        link_bit    = 1'b0;
        link_addr   = '0;
        last_va     = '0;
        ll_va       = '0;
        checks      = 0;
        val_errs    = 0;
        proto_errs  = 0;
        stim_st     = SEED;
        bus_st      = 16'(lfsr_take(stim_st, 16)) | 16'h0001;
        rdy_st      = 16'(lfsr_take(stim_st, 16)) | 16'h0001;
        for (i = 0; i < 256; i++) begin
            bus_mem[i] = fill_byte(i);
            ref_mem[i] = fill_byte(i);
        end
        for (i = 0; i < 8; i++) begin
            tlb_found_tab[i] = (3'(lfsr_take(stim_st, 3)) != 3'd0);
            tlb_valid_tab[i] = (3'(lfsr_take(stim_st, 3)) != 3'd0);
            tlb_dirty_tab[i] = 1'(lfsr_take(stim_st, 1));
            tlb_pfn_tab[i]   = 20'(lfsr_take(stim_st, 20));
            tlb_cattr_tab[i] = lfsr_take(stim_st, 1) ? `MA_CATTR_CACHED
                                                     : 3'(lfsr_take(stim_st, 3));
        end

        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_val("req_ready", req_ready, 1'b1);
        check_val("bus_req", bus_req, 1'b0);
        check_val("resp_valid", resp_valid, 1'b0);

        for (n = 0; n < N_REQ; n++) begin
            op = 4'(lfsr_take(stim_st, 4));
            if (op > `MA_OP_LL)
                op = op[0] ? `MA_OP_LL : `MA_OP_SC;   // extra ll/sc weight
            if (op == `MA_OP_SC && 2'(lfsr_take(stim_st, 2)) != 2'd0) begin
                va = ll_va;
            end else if (lfsr_take(stim_st, 1)) begin
                va = last_va;
            end else begin
                seg  = 3'(lfsr_take(stim_st, 3));
                page = 3'(lfsr_take(stim_st, 3));
                wsel = 2'(lfsr_take(stim_st, 2));
                lo   = lfsr_take(stim_st, 1) ? 2'(lfsr_take(stim_st, 2)) : 2'd0;
                va   = {seg, 14'd0, page, 8'd0, wsel, lo};
            end
            rt  = lfsr_take(stim_st, 32);
            k0  = lfsr_take(stim_st, 1) ? `MA_CATTR_CACHED : 3'(lfsr_take(stim_st, 3));
            gap = lfsr_take(stim_st, 2);
            run_request(op, va, rt, k0, gap);
            last_va = va;
            if (op == `MA_OP_LL)
                ll_va = va;
        end

        $display("%0d checks, %0d value errors, %0d protocol errors",
                 checks, val_errs, proto_errs);
        if (val_errs == 0 && proto_errs == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+src
+incdir+tests
src/mem_access_pkg.sv
src/xlate_if.sv
src/addr_translate.sv
src/exc_detect.sv
src/store_align.sv
src/load_align.sv
src/ll_link.sv
src/access_fsm.sv
src/mem_access_top.sv
tests/tb_mem_access.sv
